// ==== Bender.yml ====
package:
  name: rvv_retire

# retire stage of a vector backend with its file driven testbench
sources:
  # shared package first
  - common/rvv_retire_pkg.sv

  # design, leaf modules before the top level
  - design/retire_strobe.sv
  - design/retire_route.sv
  - design/retire_csr_update.sv
  - design/rvv_retire.sv

  # testbench, reads tests/retire_tests.txt at run time
  - target: test
    files:
      - tests/tb_rvv_retire.sv

# simulation top: tb_rvv_retire
# synthesis top: rvv_retire
# run from the project root so the test file path resolves

// ==== common/rvv_retire_pkg.sv ====
////////////////////
// shared widths and defaults for the retire stage
// vector CSR snapshot record and byte type encoding
////////////////////

package rvv_retire_pkg;

  ////////////////////
  // sizes

  // retire entries per cycle, oldest is entry 0
  localparam int NUM_RT_UOP_DEF = 4;

  // vector register width in bits
  localparam int VLEN_DEF = 128;

  // scalar register width, fixed for this core
  localparam int XLEN = 32;

  // register file index width for both files
  localparam int REG_INDEX_W = 5;

  ////////////////////
  // byte destination type

  // two bits per destination byte come from the ROB
  // only the body bytes are written by default
  // tail and masked-off bytes keep the old value unless agnostic
  localparam logic [1:0] BYTE_ACTIVE = 2'b11;

  ////////////////////
  // vector CSR snapshot

  // captured per micro-op at dispatch
  // restored into the architectural state on a trap
  typedef struct packed {
    logic [7:0] vstart; // element index to resume from
    logic [7:0] vl;     // active vector length
    logic [7:0] vtype;  // sew, lmul and policy bits
  } vcsr_t;

endpackage

// ==== design/retire_csr_update.sv ====
////////////////////
// trap CSR snapshot select and saturation event
// architectural vcsr state and sticky vxsat
////////////////////

module retire_csr_update
  import rvv_retire_pkg::*;
#(
  parameter int num_rt_uop = NUM_RT_UOP_DEF
) (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic  [num_rt_uop-1:0] uop_w_valid,
  input  logic  [num_rt_uop-1:0] uop_trap,
  input  vcsr_t [num_rt_uop-1:0] uop_vcsr,
  input  logic  [num_rt_uop-1:0] uop_vxsat,
  input  logic  [num_rt_uop-1:0] eff_valid,
  output logic                   vcsr_write_valid,
  output vcsr_t                  vcsr_write_data,
  output vcsr_t                  vcsr_state,
  output logic                   vxsat_write_valid,
  output logic                   vxsat_state
);

  ////////////////////
  // trap snapshot

  // scan from youngest to oldest, the last hit is the oldest trap
  // the raw write valid is used here since trap cancel only
  // affects entries after the first trap
  always_comb begin
    vcsr_write_valid = 1'b0;
    vcsr_write_data  = '0;
    for (int i = num_rt_uop - 1; i >= 0; i--) begin
      if (uop_w_valid[i] && uop_trap[i]) begin
        vcsr_write_valid = 1'b1;
        vcsr_write_data  = uop_vcsr[i];
      end
    end
  end

  ////////////////////
  // saturation event

  // cancelled entries must not set vxsat
  assign vxsat_write_valid = |(eff_valid & uop_vxsat);

  ////////////////////
  // CSR state

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vcsr_state <= '0;
    end else if (vcsr_write_valid) begin
      vcsr_state <= vcsr_write_data;  // restore point for the trap handler
    end
  end

  // sticky until reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vxsat_state <= 1'b0;
    end else if (vxsat_write_valid) begin
      vxsat_state <= 1'b1;
    end
  end

endmodule

// ==== design/retire_route.sv ====
////////////////////
// trap cancel and register file routing
// scalar ready return per entry
////////////////////

module retire_route
  import rvv_retire_pkg::*;
#(
  parameter int num_rt_uop = NUM_RT_UOP_DEF,
  parameter int vlen       = VLEN_DEF
) (
  input  logic [num_rt_uop-1:0]                   uop_w_valid,
  input  logic [num_rt_uop-1:0]                   uop_w_type,
  input  logic [num_rt_uop-1:0][REG_INDEX_W-1:0]  uop_w_index,
  input  logic [num_rt_uop-1:0][vlen-1:0]         uop_w_data,
  input  logic [num_rt_uop-1:0]                   uop_trap,
  input  logic [num_rt_uop-1:0]                   xrf_ready,
  output logic [num_rt_uop-1:0]                   eff_valid,
  output logic [num_rt_uop-1:0]                   vrf_valid,
  output logic [num_rt_uop-1:0][REG_INDEX_W-1:0]  vrf_index,
  output logic [num_rt_uop-1:0][vlen-1:0]         vrf_data,
  output logic [num_rt_uop-1:0]                   xrf_valid,
  output logic [num_rt_uop-1:0][REG_INDEX_W-1:0]  xrf_index,
  output logic [num_rt_uop-1:0][XLEN-1:0]         xrf_data,
  output logic [num_rt_uop-1:0]                   rob_ready
);

  ////////////////////
  // trap cancel

  // trapping entry still writes, everything younger is dropped
  always_comb begin
    logic trap_seen;
    trap_seen = 1'b0;
    for (int i = 0; i < num_rt_uop; i++) begin
      eff_valid[i] = uop_w_valid[i] && !trap_seen;
      trap_seen    = trap_seen || uop_trap[i];
    end
  end

  ////////////////////
  // vector or scalar split

  assign vrf_valid = eff_valid & ~uop_w_type;
  assign xrf_valid = eff_valid & uop_w_type;

  assign vrf_index = uop_w_index;
  assign vrf_data  = uop_w_data;
  assign xrf_index = uop_w_index;

  always_comb begin
    for (int i = 0; i < num_rt_uop; i++) begin
      xrf_data[i] = uop_w_data[i][XLEN-1:0]; // low lanes only
      // only a scalar write waits on the XRF port
      rob_ready[i] = xrf_valid[i] ? xrf_ready[i] : 1'b1;
    end
  end

endmodule

// ==== design/retire_strobe.sv ====
////////////////////
// vector write byte strobes
// agnostic override, destination grouping, WAW pruning
////////////////////

module retire_strobe
  import rvv_retire_pkg::*;
#(
  parameter int   num_rt_uop = NUM_RT_UOP_DEF,
  parameter int   vlen       = VLEN_DEF,
  localparam int  vlenb      = vlen / 8
) (
  input  logic [num_rt_uop-1:0]                    rob_valid,
  input  logic [num_rt_uop-1:0]                    uop_w_type,
  input  logic [num_rt_uop-1:0][REG_INDEX_W-1:0]   uop_w_index,
  input  logic [num_rt_uop-1:0][vlenb-1:0][1:0]    uop_vd_type,
  input  logic [num_rt_uop-1:0]                    uop_ignore_vta,
  input  logic [num_rt_uop-1:0]                    uop_ignore_vma,
  output logic [num_rt_uop-1:0][vlenb-1:0]         vrf_strobe
);

  logic [num_rt_uop-1:0][vlenb-1:0] base_strobe;  // before WAW pruning
  logic [num_rt_uop-1:0]            in_group;     // same destination as entry 0
  logic [num_rt_uop-1:0][vlenb-1:0] prune_strobe;

  ////////////////////
  // base strobe

  // body bytes only, unless either agnostic flag lets the
  // whole register be overwritten
  always_comb begin
    for (int i = 0; i < num_rt_uop; i++) begin
      for (int b = 0; b < vlenb; b++) begin
        base_strobe[i][b] = (uop_vd_type[i][b] == BYTE_ACTIVE) ||
                            uop_ignore_vta[i] || uop_ignore_vma[i];
      end
    end
  end

  ////////////////////
  // destination group

  // prefix of entries that agree with entry 0 on valid and type
  // first mismatch ends the group for all younger entries
  always_comb begin
    in_group[0] = 1'b1;
    for (int i = 1; i < num_rt_uop; i++) begin
      in_group[i] = in_group[i-1] &&
                    (rob_valid[i] == rob_valid[0]) &&
                    (uop_w_type[i] == uop_w_type[0]);
    end
  end

  ////////////////////
  // WAW pruning

  // walk from the youngest entry down so each younger strobe is
  // already final when an older entry looks at it
  // the youngest entry is never pruned
  always_comb begin
    prune_strobe = base_strobe;
    for (int i = num_rt_uop - 2; i >= 0; i--) begin
      for (int j = i + 1; j < num_rt_uop; j++) begin
        // j in the group implies i is too
        if (in_group[j] && (uop_w_index[j] == uop_w_index[i])) begin
          prune_strobe[i] = prune_strobe[i] & ~prune_strobe[j]; // younger wins
        end
      end
    end
  end

  assign vrf_strobe = prune_strobe;

endmodule

// ==== design/rvv_retire.sv ====
////////////////////
// retire stage top level
// strobe generation, routing and CSR update wired together
////////////////////

module rvv_retire
  import rvv_retire_pkg::*;
#(
  parameter int   num_rt_uop = NUM_RT_UOP_DEF,
  parameter int   vlen       = VLEN_DEF,
  localparam int  vlenb      = vlen / 8
) (
  input  logic                                       clk,
  input  logic                                       arst_n,

  // from the reorder buffer, entry 0 is the oldest
  input  logic  [num_rt_uop-1:0]                     rob_valid,
  input  logic  [num_rt_uop-1:0]                     uop_w_valid,
  input  logic  [num_rt_uop-1:0]                     uop_w_type,   // 1 means scalar
  input  logic  [num_rt_uop-1:0][REG_INDEX_W-1:0]    uop_w_index,
  input  logic  [num_rt_uop-1:0][vlen-1:0]           uop_w_data,
  input  logic  [num_rt_uop-1:0][vlenb-1:0][1:0]     uop_vd_type,
  input  logic  [num_rt_uop-1:0]                     uop_ignore_vta,
  input  logic  [num_rt_uop-1:0]                     uop_ignore_vma,
  input  logic  [num_rt_uop-1:0]                     uop_trap,
  input  vcsr_t [num_rt_uop-1:0]                     uop_vcsr,
  input  logic  [num_rt_uop-1:0]                     uop_vxsat,
  output logic  [num_rt_uop-1:0]                     rob_ready,

  // vector register file writes, no back-pressure
  output logic  [num_rt_uop-1:0]                     vrf_valid,
  output logic  [num_rt_uop-1:0][REG_INDEX_W-1:0]    vrf_index,
  output logic  [num_rt_uop-1:0][vlen-1:0]           vrf_data,
  output logic  [num_rt_uop-1:0][vlenb-1:0]          vrf_strobe,

  // scalar register file writes
  output logic  [num_rt_uop-1:0]                     xrf_valid,
  output logic  [num_rt_uop-1:0][REG_INDEX_W-1:0]    xrf_index,
  output logic  [num_rt_uop-1:0][XLEN-1:0]           xrf_data,
  input  logic  [num_rt_uop-1:0]                     xrf_ready,

  // CSR side
  output logic                                       vcsr_write_valid,
  output vcsr_t                                      vcsr_write_data,
  output vcsr_t                                      vcsr_state,
  output logic                                       vxsat_write_valid,
  output logic                                       vxsat_state
);

  logic [num_rt_uop-1:0] eff_valid; // write valid after trap cancel

  ////////////////////
  // byte strobes

  retire_strobe #(
    .num_rt_uop     (num_rt_uop),
    .vlen           (vlen)
  ) i_retire_strobe (
    .rob_valid      (rob_valid),
    .uop_w_type     (uop_w_type),
    .uop_w_index    (uop_w_index),
    .uop_vd_type    (uop_vd_type),
    .uop_ignore_vta (uop_ignore_vta),
    .uop_ignore_vma (uop_ignore_vma),
    .vrf_strobe     (vrf_strobe)
  );

  ////////////////////
  // register file routing

  retire_route #(
    .num_rt_uop  (num_rt_uop),
    .vlen        (vlen)
  ) i_retire_route (
    .uop_w_valid (uop_w_valid),
    .uop_w_type  (uop_w_type),
    .uop_w_index (uop_w_index),
    .uop_w_data  (uop_w_data),
    .uop_trap    (uop_trap),
    .xrf_ready   (xrf_ready),
    .eff_valid   (eff_valid),
    .vrf_valid   (vrf_valid),
    .vrf_index   (vrf_index),
    .vrf_data    (vrf_data),
    .xrf_valid   (xrf_valid),
    .xrf_index   (xrf_index),
    .xrf_data    (xrf_data),
    .rob_ready   (rob_ready)
  );

  ////////////////////
  // CSR update and state

  retire_csr_update #(
    .num_rt_uop        (num_rt_uop)
  ) i_retire_csr_update (
    .clk               (clk),
    .arst_n            (arst_n),
    .uop_w_valid       (uop_w_valid),
    .uop_trap          (uop_trap),
    .uop_vcsr          (uop_vcsr),
    .uop_vxsat         (uop_vxsat),
    .eff_valid         (eff_valid),
    .vcsr_write_valid  (vcsr_write_valid),
    .vcsr_write_data   (vcsr_write_data),
    .vcsr_state        (vcsr_state),
    .vxsat_write_valid (vxsat_write_valid),
    .vxsat_state       (vxsat_state)
  );

endmodule

// ==== tests/retire_tests.txt ====
# name rob_valid w_valid w_type index vd_type vta vma trap vxsat vcsr xrf_ready, then expected
# vrf_valid xrf_valid rob_ready strobe vcsr_wvalid vcsr_wdata vxsat_wvalid vcsr_state vxsat_state
# one bit per entry with entry 0 in the lsb, wide fields list entry 3 first, index is a byte each
# routing and pass-through
route_vec  f f 0 04030201 ffffffffffffffff 0 0 0 0 000000000000000000000000 f  f 0 f ffffffff 0 000000 0 000000 0
route_sca  f f f 1f1e1d1c ffffffffffffffff 0 0 0 0 000000000000000000000000 f  0 f f ffffffff 0 000000 0 000000 0
route_mix  f f a 08070605 ffffffffffffffff 0 0 0 0 000000000000000000000000 f  5 a f ffffffff 0 000000 0 000000 0
route_wv   f 6 c 0a0b0c0d ffffffffffffffff 0 0 0 0 000000000000000000000000 f  2 4 f ffffffff 0 000000 0 000000 0
route_idle 0 0 0 00000000 ffffffffffffffff 0 0 0 0 000000000000000000000000 f  0 0 f ff000000 0 000000 0 000000 0
route_idx  3 3 2 0011091f ffffffffffffffff 0 0 0 0 000000000000000000000000 f  1 2 f ffffffff 0 000000 0 000000 0
# strobe from byte type and agnostic flags
strb_body  f f 0 03020100 00ff0f0ff0f03333 0 0 0 0 000000000000000000000000 f  f 0 f 0f33cc55 0 000000 0 000000 0
strb_codes f f 0 03020100 5555aaaa7777dddd 0 0 0 0 000000000000000000000000 f  f 0 f 000055aa 0 000000 0 000000 0
strb_vta   f f 0 03020100 0000000000000000 5 0 0 0 000000000000000000000000 f  f 0 f 00ff00ff 0 000000 0 000000 0
strb_vma   f f 0 03020100 000f000f000f000f 0 a 0 0 000000000000000000000000 f  f 0 f ff03ff03 0 000000 0 000000 0
strb_both  f f 0 03020100 0000000000000000 3 6 0 0 000000000000000000000000 f  f 0 f 00ffffff 0 000000 0 000000 0
# write-after-write pruning inside the group
waw_all    f f 0 05050505 ffffffffffffffff 0 0 0 0 000000000000000000000000 f  f 0 f ff000000 0 000000 0 000000 0
waw_03_12  f f 0 07090907 00ffff00ffffffff 0 0 0 0 000000000000000000000000 f  f 0 f 0ff00ff0 0 000000 0 000000 0
waw_01     f f 0 04030202 ffffffff0f0fffff 0 0 0 0 000000000000000000000000 f  f 0 f ffff33cc 0 000000 0 000000 0
waw_chain  f f 0 06060606 0003000f00ffffff 0 0 0 0 000000000000000000000000 f  f 0 f 01020cf0 0 000000 0 000000 0
waw_brk_ty f f 4 06060606 ffffffffffffffff 0 0 0 0 000000000000000000000000 f  b 4 f ffffff00 0 000000 0 000000 0
waw_brk_rv 7 7 0 06060606 ffffffffffffffff 0 0 0 0 000000000000000000000000 f  7 0 f ffff0000 0 000000 0 000000 0
waw_sca    f f f 01020102 ffffffffffffffff 0 0 0 0 000000000000000000000000 f  0 f f ffff0000 0 000000 0 000000 0
waw_agn    f f 0 0a0a0a0a 000000000000ffff 0 4 0 0 000000000000000000000000 f  f 0 f 00ff0000 0 000000 0 000000 0
# back-pressure on the scalar port
bp_mix     f f a 04030201 ffffffffffffffff 0 0 0 0 000000000000000000000000 0  5 a 5 ffffffff 0 000000 0 000000 0
bp_part    f f f 04030201 ffffffffffffffff 0 0 0 0 000000000000000000000000 6  0 f 6 ffffffff 0 000000 0 000000 0
bp_inval   f 3 f 04030201 ffffffffffffffff 0 0 0 0 000000000000000000000000 0  0 3 c ffffffff 0 000000 0 000000 0
bp_idle    0 0 f 04030201 ffffffffffffffff 0 0 0 0 000000000000000000000000 0  0 0 f ffffffff 0 000000 0 000000 0
# traps, cancellation and CSR snapshot
trap_e1    f f 0 04030201 ffffffffffffffff 0 0 2 0 a3a3a3a2a2a2a1a1a1a0a0a0 f  3 0 f ffffffff 1 a1a1a1 0 a1a1a1 0
trap_two   f f 2 04030201 ffffffffffffffff 0 0 a 0 b3b3b3b2b2b2b1b1b1b0b0b0 f  1 2 f ffffffff 1 b1b1b1 0 b1b1b1 0
trap_nowv  f e 0 04030201 ffffffffffffffff 0 0 1 0 c3c3c3c2c2c2c1c1c1c0c0c0 f  0 0 f ffffffff 0 000000 0 b1b1b1 0
trap_skip  f e 0 04030201 ffffffffffffffff 0 0 5 0 d3d3d3d2d2d2d1d1d1d0d0d0 f  0 0 f ffffffff 1 d2d2d2 0 d2d2d2 0
trap_e0    f f f 04030201 ffffffffffffffff 0 0 1 0 e3e3e3e2e2e2e1e1e1e0e0e0 f  0 1 f ffffffff 1 e0e0e0 0 e0e0e0 0
trap_e3    f f 0 04030201 ffffffffffffffff 0 0 8 0 f3f3f3f2f2f2f1f1f1f0f0f0 f  f 0 f ffffffff 1 f3f3f3 0 f3f3f3 0
# saturation and sticky vxsat
sat_cancel f f 0 04030201 ffffffffffffffff 0 0 1 e 000000000000000000000000 f  1 0 f ffffffff 1 000000 0 000000 0
sat_nowv   f 0 0 04030201 ffffffffffffffff 0 0 0 f 000000000000000000000000 f  0 0 f ffffffff 0 000000 0 000000 0
sat_set    f f 0 04030201 ffffffffffffffff 0 0 0 4 000000000000000000000000 f  f 0 f ffffffff 0 000000 1 000000 1
sat_hold   f f 0 04030201 ffffffffffffffff 0 0 0 0 000000000000000000000000 f  f 0 f ffffffff 0 000000 0 000000 1
sat_trap   f f 0 04030201 ffffffffffffffff 0 0 2 2 000000000000123456000000 f  3 0 f ffffffff 1 123456 1 123456 1
sat_tail   f 7 0 04030201 ffffffffffffffff 0 0 0 8 000000000000000000000000 f  7 0 f ffffffff 0 000000 0 123456 1

// ==== tests/tb_rvv_retire.sv ====
////////////////////
// testbench for the retire stage
// file driven stimulus, field checks, per-test report
////////////////////

module tb_rvv_retire
  import rvv_retire_pkg::*;
();

  localparam int num_rt_uop = 4;
  localparam int vlen       = 64;  // eight byte lanes per entry
  localparam int vlenb      = vlen / 8;
  localparam int num_fields = 21;  // columns per test line

  logic                                    clk;
  logic                                    arst_n;
  logic  [num_rt_uop-1:0]                  rob_valid;
  logic  [num_rt_uop-1:0]                  uop_w_valid;
  logic  [num_rt_uop-1:0]                  uop_w_type;
  logic  [num_rt_uop-1:0][REG_INDEX_W-1:0] uop_w_index;
  logic  [num_rt_uop-1:0][vlen-1:0]        uop_w_data;
  logic  [num_rt_uop-1:0][vlenb-1:0][1:0]  uop_vd_type;
  logic  [num_rt_uop-1:0]                  uop_ignore_vta;
  logic  [num_rt_uop-1:0]                  uop_ignore_vma;
  logic  [num_rt_uop-1:0]                  uop_trap;
  vcsr_t [num_rt_uop-1:0]                  uop_vcsr;
  logic  [num_rt_uop-1:0]                  uop_vxsat;
  logic  [num_rt_uop-1:0]                  rob_ready;
  logic  [num_rt_uop-1:0]                  vrf_valid;
  logic  [num_rt_uop-1:0][REG_INDEX_W-1:0] vrf_index;
  logic  [num_rt_uop-1:0][vlen-1:0]        vrf_data;
  logic  [num_rt_uop-1:0][vlenb-1:0]       vrf_strobe;
  logic  [num_rt_uop-1:0]                  xrf_valid;
  logic  [num_rt_uop-1:0][REG_INDEX_W-1:0] xrf_index;
  logic  [num_rt_uop-1:0][XLEN-1:0]        xrf_data;
  logic  [num_rt_uop-1:0]                  xrf_ready;
  logic                                    vcsr_write_valid;
  vcsr_t                                   vcsr_write_data;
  vcsr_t                                   vcsr_state;
  logic                                    vxsat_write_valid;
  logic                                    vxsat_state;

  string  test_lines[$];  // raw lines, parsed when each test runs
  integer seed;
  int     error_count;
  int     failed_tests;
  int     cycle_count;
  int     cycle_limit;

  rvv_retire #(
    .num_rt_uop        (num_rt_uop),
    .vlen              (vlen)
  ) i_rvv_retire (
    .clk               (clk),
    .arst_n            (arst_n),
    .rob_valid         (rob_valid),
    .uop_w_valid       (uop_w_valid),
    .uop_w_type        (uop_w_type),
    .uop_w_index       (uop_w_index),
    .uop_w_data        (uop_w_data),
    .uop_vd_type       (uop_vd_type),
    .uop_ignore_vta    (uop_ignore_vta),
    .uop_ignore_vma    (uop_ignore_vma),
    .uop_trap          (uop_trap),
    .uop_vcsr          (uop_vcsr),
    .uop_vxsat         (uop_vxsat),
    .rob_ready         (rob_ready),
    .vrf_valid         (vrf_valid),
    .vrf_index         (vrf_index),
    .vrf_data          (vrf_data),
    .vrf_strobe        (vrf_strobe),
    .xrf_valid         (xrf_valid),
    .xrf_index         (xrf_index),
    .xrf_data          (xrf_data),
    .xrf_ready         (xrf_ready),
    .vcsr_write_valid  (vcsr_write_valid),
    .vcsr_write_data   (vcsr_write_data),
    .vcsr_state        (vcsr_state),
    .vxsat_write_valid (vxsat_write_valid),
    .vxsat_state       (vxsat_state)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////
  // helpers

  task automatic compare_field(input string test_name, input string field,
                               input logic [127:0] expected, input logic [127:0] actual);
    assert (actual === expected) else begin
      $display("MISMATCH test %s field %s expected %0h actual %0h",
               test_name, field, expected, actual);
      error_count++;
    end
  endtask

  // comment and blank lines are skipped
  task automatic load_tests(output int ok);
    int    fd;
    int    r;
    string line;
    fd = $fopen("tests/retire_tests.txt", "r");
    ok = (fd != 0);
    if (ok) begin
      while (!$feof(fd)) begin
        line = "";
        r    = $fgets(line, fd);
        if (r > 0 && line.len() > 1 && line.getc(0) != "#") begin
          test_lines.push_back(line);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_test(input string line);
    string                                  name;
    logic [3:0]                             rv, wv, ty, vta, vma, trap, vxs, xrdy;
    logic [31:0]                            idx_word;     // one byte per entry
    logic [63:0]                            vd_word;
    logic [95:0]                            vcsr_word;
    logic [3:0]                             exp_vrfv, exp_xrfv, exp_rdy;
    logic [31:0]                            exp_strobe;
    logic                                   exp_cwv, exp_sv, exp_sst;
    logic [23:0]                            exp_cwd, exp_cst;
    logic [num_rt_uop-1:0][vlen-1:0]        data;
    logic [num_rt_uop-1:0][REG_INDEX_W-1:0] index;
    int                                     fields;
    int                                     errors_before;
    errors_before = error_count;
    fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                     name, rv, wv, ty, idx_word, vd_word, vta, vma, trap, vxs, vcsr_word,
                     xrdy, exp_vrfv, exp_xrfv, exp_rdy, exp_strobe, exp_cwv, exp_cwd,
                     exp_sv, exp_cst, exp_sst);
    if (fields != num_fields) begin
      $display("test line could not be read, only %0d fields: %s", fields, line);
      error_count++;
      failed_tests++;
    end else begin
      for (int i = 0; i < num_rt_uop; i++) begin
        data[i]  = {$random(seed), $random(seed)};
        index[i] = idx_word[8*i +: REG_INDEX_W];
      end
      @(posedge clk);
      rob_valid      <= rv;
      uop_w_valid    <= wv;
      uop_w_type     <= ty;
      uop_w_index    <= index;
      uop_w_data     <= data;
      uop_vd_type    <= vd_word;
      uop_ignore_vta <= vta;
      uop_ignore_vma <= vma;
      uop_trap       <= trap;
      uop_vcsr       <= vcsr_word;
      uop_vxsat      <= vxs;
      xrf_ready      <= xrdy;
      #1;  // combinational outputs settled
      compare_field(name, "vrf_valid", exp_vrfv, vrf_valid);
      compare_field(name, "xrf_valid", exp_xrfv, xrf_valid);
      compare_field(name, "rob_ready", exp_rdy, rob_ready);
      compare_field(name, "vrf_strobe", exp_strobe, vrf_strobe);
      compare_field(name, "vcsr_write_valid", exp_cwv, vcsr_write_valid);
      compare_field(name, "vcsr_write_data", exp_cwd, vcsr_write_data);
      compare_field(name, "vxsat_write_valid", exp_sv, vxsat_write_valid);
      for (int i = 0; i < num_rt_uop; i++) begin
        compare_field(name, $sformatf("vrf_index[%0d]", i), index[i], vrf_index[i]);
        compare_field(name, $sformatf("vrf_data[%0d]", i), data[i], vrf_data[i]);
        compare_field(name, $sformatf("xrf_index[%0d]", i), index[i], xrf_index[i]);
        compare_field(name, $sformatf("xrf_data[%0d]", i), data[i][XLEN-1:0], xrf_data[i]);
      end
      @(posedge clk);
      #1;  // state loaded at this edge
      compare_field(name, "vcsr_state", exp_cst, vcsr_state);
      compare_field(name, "vxsat_state", exp_sst, vxsat_state);
      if (error_count == errors_before) begin
        $display("test %s passed", name);
      end else begin
        $display("test %s failed with %0d mismatches", name, error_count - errors_before);
        failed_tests++;
      end
    end
  endtask

  ////////////////////
  // timeout

  initial begin
    cycle_count = 0;
    wait (cycle_limit > 0);
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout after %0d cycles, the test sequence did not finish", cycle_count);
    $display("ERRORS FOUND");
    $finish;
  end

  ////////////////////
  // main sequence

  initial begin
    int loaded;
    seed           = 32'hbbe6_8229;
    error_count    = 0;
    failed_tests   = 0;
    arst_n         = 1'b0;
    rob_valid      = '0;
    uop_w_valid    = '0;
    uop_w_type     = '0;
    uop_w_index    = '0;
    uop_w_data     = '0;
    uop_vd_type    = '0;
    uop_ignore_vta = '0;
    uop_ignore_vma = '0;
    uop_trap       = '0;
    uop_vcsr       = '0;
    uop_vxsat      = '0;
    xrf_ready      = '0;
    load_tests(loaded);
    if (loaded == 0) begin
      $display("test file tests/retire_tests.txt could not be opened");
      $display("ERRORS FOUND");
      $finish;
    end else begin
      cycle_limit = 3 * test_lines.size() + 20;  // two cycles per test plus reset
      repeat (4) @(posedge clk);
      arst_n <= 1'b1;
      @(posedge clk);
      #1;
      compare_field("reset", "vcsr_state", '0, vcsr_state);
      compare_field("reset", "vxsat_state", '0, vxsat_state);
      foreach (test_lines[t]) begin
        run_test(test_lines[t]);
      end
      $display("tests run %0d, tests failed %0d, mismatches %0d",
               test_lines.size(), failed_tests, error_count);
      if (error_count == 0) begin
        $display("NO ERRORS");
      end else begin
        $display("ERRORS FOUND");
      end
      $finish;
    end
  end

endmodule

// ==== verilog.f ====
common/rvv_retire_pkg.sv
design/retire_strobe.sv
design/retire_route.sv
design/retire_csr_update.sv
design/rvv_retire.sv
tests/tb_rvv_retire.sv
